/* logic/perf_defines.svh */
// Widths, counts and register map of the performance-counter block, included by RTL and testbench
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

// --------------------
// Sizes
// --------------------
`define PERF_DATA_W      32  // Bus and counter width
`define PERF_NUM_CNT     4
`define PERF_NUM_EVENTS  8
`define PERF_SEL_W       4
`define PERF_ADDR_W      6   // Byte address with the word index in bits 5..2

// --------------------
// Register word indices
// --------------------
`define PERF_REG_CNT0    0   // Counters 0..3
`define PERF_REG_SEL0    4   // Selectors 4..7
`define PERF_REG_THR0    8   // Thresholds 8..11
`define PERF_REG_MADDR   12
`define PERF_REG_CFG     13  // Sample mask in bits 3..0

// Address increment per stored sample word
`define PERF_STORE_STEP  4

`endif

/* logic/perf_pkg.sv */
// Shared types of the performance-counter block; modules import them with perf_pkg::*
`include "perf_defines.svh"

package perf_pkg;

  // --------------------
  // Data words
  // --------------------
  typedef logic [`PERF_DATA_W-1:0] word_t;

  // All counters side by side, index 0 in the low word
  typedef logic [`PERF_NUM_CNT-1:0][`PERF_DATA_W-1:0] cnt_vec_t;

  // --------------------
  // Event selection
  // --------------------
  // 0 is no event, 1..8 pick strobe code-1, anything above is no event too
  typedef logic [`PERF_SEL_W-1:0] sel_t;

  typedef logic [`PERF_NUM_CNT-1:0][`PERF_SEL_W-1:0] sel_vec_t;

  // --------------------
  // Sampler
  // --------------------
  typedef enum logic {
    SMP_IDLE  = 1'b0,  // Comparing counters against thresholds
    SMP_STORE = 1'b1   // Writing PC and masked counters to memory
  } sample_state_e;

endpackage

/* logic/perf_event_mux.sv */
// Per-counter event selection and event-PC capture, instantiated once inside perf_top
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_event_mux import perf_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [`PERF_NUM_EVENTS-1:0] event_i,
  input  word_t                       pc_i,
  input  sel_vec_t                    sel_vec_i,
  output logic [`PERF_NUM_CNT-1:0]    hit_o,
  output cnt_vec_t                    event_pc_o   // Last event PC, one word per counter
);

  for (genvar k = 0; k < `PERF_NUM_CNT; k++) begin : g_cnt
    sel_t  sel;
    logic  hit;
    word_t pc_q;

    assign sel = sel_vec_i[k];

    // Code e+1 picks strobe e, all other codes leave hit low
    always_comb begin
      hit = 1'b0;
      for (int e = 0; e < `PERF_NUM_EVENTS; e++) begin
        if (sel == `PERF_SEL_W'(e + 1)) begin
          hit = event_i[e];
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        pc_q <= '0;
      end else if (hit) begin
        pc_q <= pc_i;  // PC of the instruction behind this event
      end
    end

    assign hit_o[k]      = hit;
    assign event_pc_o[k] = pc_q;
  end

endmodule

/* logic/perf_counter_bank.sv */
// Bank of event counters with inhibit, debug freeze and software write, used inside perf_top
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_counter_bank import perf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`PERF_NUM_CNT-1:0] hit_i,
  input  logic [`PERF_NUM_CNT-1:0] inhibit_i,
  input  logic                     debug_mode_i,
  input  logic                     hold_cnt_i,   // Register write in progress
  input  logic                     cnt_we_i,
  input  logic [1:0]               cnt_widx_i,
  input  word_t                    cnt_wdata_i,
  output cnt_vec_t                 cnt_vec_o
);

  cnt_vec_t                 cnt_q;
  logic [`PERF_NUM_CNT-1:0] cnt_en;

  // Counting pauses for the whole bank in debug mode and during writes
  always_comb begin
    for (int k = 0; k < `PERF_NUM_CNT; k++) begin
      cnt_en[k] = hit_i[k] && !inhibit_i[k] && !debug_mode_i && !hold_cnt_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_we_i) begin
      cnt_q[cnt_widx_i] <= cnt_wdata_i;  // Other counters frozen this cycle
    end else begin
      for (int k = 0; k < `PERF_NUM_CNT; k++) begin
        if (cnt_en[k]) begin
          cnt_q[k] <= cnt_q[k] + word_t'(1);  // Wraps at full width
        end
      end
    end
  end

  assign cnt_vec_o = cnt_q;

endmodule

/* logic/perf_csr_regs.sv */
// Wishbone slave with the configuration registers of the counter block, instantiated by perf_top
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_csr_regs import perf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wbs_cyc_i,
  input  logic                     wbs_stb_i,
  input  logic                     wbs_we_i,
  input  logic [`PERF_ADDR_W-1:0]  wbs_adr_i,
  input  word_t                    wbs_dat_i,
  input  cnt_vec_t                 cnt_vec_i,
  output logic                     wbs_ack_o,
  output word_t                    wbs_dat_o,
  output sel_vec_t                 sel_vec_o,
  output cnt_vec_t                 thr_vec_o,
  output word_t                    maddr_o,
  output logic [`PERF_NUM_CNT-1:0] sample_mask_o,
  output logic                     cnt_we_o,
  output logic [1:0]               cnt_widx_o,
  output word_t                    cnt_wdata_o,
  output logic                     hold_cnt_o
);

  localparam int unsigned IdxW = `PERF_ADDR_W - 2;

  logic [IdxW-1:0]          word_idx;
  logic [1:0]               sub_idx;   // Bank bases are multiples of 4
  logic                     req;
  logic                     wr_en;
  logic                     hit_cnt;
  logic                     hit_sel;
  logic                     hit_thr;
  logic                     ack_q;
  word_t                    rdata;
  word_t                    rdata_q;
  sel_vec_t                 sel_q;
  cnt_vec_t                 thr_q;
  word_t                    maddr_q;
  logic [`PERF_NUM_CNT-1:0] mask_q;

  function automatic logic in_bank(input logic [IdxW-1:0] idx, input int unsigned base);
    return (32'(idx) >= base) && (32'(idx) < base + `PERF_NUM_CNT);
  endfunction

  // --------------------
  // Decode
  // --------------------
  assign word_idx = wbs_adr_i[`PERF_ADDR_W-1:2];
  assign sub_idx  = word_idx[1:0];
  assign req      = wbs_cyc_i && wbs_stb_i;
  assign wr_en    = req && wbs_we_i && ack_q;  // Writes land on the ack edge
  assign hit_cnt  = in_bank(word_idx, `PERF_REG_CNT0);
  assign hit_sel  = in_bank(word_idx, `PERF_REG_SEL0);
  assign hit_thr  = in_bank(word_idx, `PERF_REG_THR0);

  always_comb begin
    rdata = '0;  // Unmapped words read zero
    if (hit_cnt) begin
      rdata = cnt_vec_i[sub_idx];
    end else if (hit_sel) begin
      rdata = word_t'(sel_q[sub_idx]);
    end else if (hit_thr) begin
      rdata = thr_q[sub_idx];
    end else if (word_idx == IdxW'(`PERF_REG_MADDR)) begin
      rdata = maddr_q;
    end else if (word_idx == IdxW'(`PERF_REG_CFG)) begin
      rdata = word_t'(mask_q);
    end
  end

  // --------------------
  // Ack and registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
      sel_q   <= '0;
      thr_q   <= '0;
      maddr_q <= '0;
      mask_q  <= '0;
    end else begin
      ack_q <= req && !ack_q;  // One-cycle ack per access
      if (req && !ack_q) begin
        rdata_q <= rdata;
      end
      if (wr_en) begin
        if (hit_sel) sel_q[sub_idx] <= wbs_dat_i[`PERF_SEL_W-1:0];
        if (hit_thr) thr_q[sub_idx] <= wbs_dat_i;
        if (word_idx == IdxW'(`PERF_REG_MADDR)) maddr_q <= wbs_dat_i;
        if (word_idx == IdxW'(`PERF_REG_CFG)) mask_q <= wbs_dat_i[`PERF_NUM_CNT-1:0];
      end
    end
  end

  assign wbs_ack_o     = ack_q;
  assign wbs_dat_o     = rdata_q;
  assign sel_vec_o     = sel_q;
  assign thr_vec_o     = thr_q;
  assign maddr_o       = maddr_q;
  assign sample_mask_o = mask_q;

  // Counter writes go to the bank, which owns the counters
  assign cnt_we_o    = wr_en && hit_cnt;
  assign cnt_widx_o  = sub_idx;
  assign cnt_wdata_o = wbs_dat_i;
  assign hold_cnt_o  = req && wbs_we_i;

endmodule

/* logic/perf_sample_fsm.sv */
// Threshold comparison and sequencing of event-based sample stores, used inside perf_top
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_sample_fsm import perf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  cnt_vec_t                 cnt_vec_i,
  input  cnt_vec_t                 thr_vec_i,
  input  logic [`PERF_NUM_CNT-1:0] sample_mask_i,
  input  logic                     store_done_i,
  output logic                     capture_o,
  output logic [1:0]               trig_idx_o,
  output logic                     store_req_o,
  output logic [2:0]               store_idx_o,  // 0 is the PC, 1..4 the counters
  output sample_state_e            state_o
);

  sample_state_e state_q;
  logic [2:0]    idx_q;
  cnt_vec_t      off_q;      // Counter value at the last trigger
  logic          trig;
  logic [1:0]    trig_idx;
  logic [1:0]    mask_sel;
  logic          step;

  // Later counters override earlier ones, so the highest index wins
  always_comb begin
    trig     = 1'b0;
    trig_idx = '0;
    for (int k = 0; k < `PERF_NUM_CNT; k++) begin
      if ((thr_vec_i[k] != '0) &&
          ({1'b0, cnt_vec_i[k]} >= {1'b0, thr_vec_i[k]} + {1'b0, off_q[k]})) begin
        trig     = 1'b1;
        trig_idx = 2'(k);
      end
    end
  end

  assign capture_o  = (state_q == SMP_IDLE) && trig;
  assign trig_idx_o = trig_idx;

  // --------------------
  // Store sequence
  // --------------------
  assign mask_sel    = idx_q[1:0] - 2'd1;
  assign store_req_o = (state_q == SMP_STORE) && ((idx_q == 3'd0) || sample_mask_i[mask_sel]);
  assign step        = (state_q == SMP_STORE) && (!store_req_o || store_done_i);  // Skip or ack

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SMP_IDLE;
      idx_q   <= '0;
      off_q   <= '0;
    end else if (capture_o) begin
      off_q[trig_idx] <= cnt_vec_i[trig_idx];
      state_q         <= SMP_STORE;
      idx_q           <= '0;
    end else if (step) begin
      if (idx_q == 3'(`PERF_NUM_CNT)) begin
        state_q <= SMP_IDLE;
        idx_q   <= '0;
      end else begin
        idx_q <= idx_q + 3'd1;
      end
    end
  end

  assign store_idx_o = idx_q;
  assign state_o     = state_q;

endmodule

/* logic/perf_sample_store.sv */
// Sample snapshot registers and the Wishbone store master, driven by perf_sample_fsm in perf_top
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_sample_store import perf_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          capture_i,
  input  logic [1:0]    trig_idx_i,
  input  cnt_vec_t      cnt_vec_i,
  input  cnt_vec_t      event_pc_i,
  input  word_t         maddr_i,
  input  logic          store_req_i,
  input  logic [2:0]    store_idx_i,
  input  sample_state_e state_i,
  input  logic          wbm_ack_i,
  output logic          wbm_cyc_o,
  output logic          wbm_stb_o,
  output logic          wbm_we_o,
  output word_t         wbm_adr_o,
  output word_t         wbm_dat_o,
  output logic          store_done_o
);

  word_t      snap_pc_q;
  cnt_vec_t   snap_cnt_q;
  word_t      store_off_q;  // Keeps growing across samples
  logic [1:0] cnt_sel;
  logic       active;

  // --------------------
  // Snapshot
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      snap_pc_q  <= '0;
      snap_cnt_q <= '0;
    end else if (capture_i) begin
      snap_cnt_q <= cnt_vec_i;
      snap_pc_q  <= event_pc_i[trig_idx_i];  // PC of the triggering counter's event
    end
  end

  // --------------------
  // Wishbone master
  // --------------------
  // Index and offset only move on ack, so the bus stays stable while waiting
  assign active  = (state_i == SMP_STORE) && store_req_i;
  assign cnt_sel = store_idx_i[1:0] - 2'd1;

  assign wbm_cyc_o = active;
  assign wbm_stb_o = active;
  assign wbm_we_o  = active;  // Write-only master
  assign wbm_adr_o = maddr_i + store_off_q;

  always_comb begin
    wbm_dat_o = '0;
    if (active) begin
      wbm_dat_o = (store_idx_i == 3'd0) ? snap_pc_q : snap_cnt_q[cnt_sel];
    end
  end

  assign store_done_o = active && wbm_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_off_q <= '0;
    end else if (store_done_o) begin
      store_off_q <= store_off_q + word_t'(`PERF_STORE_STEP);
    end
  end

endmodule

/* logic/perf_top.sv */
// Top level of the performance-counter block, instantiated by the core or a testbench as the DUT
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_top import perf_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Wishbone slave, register access
  input  logic                        wbs_cyc_i,
  input  logic                        wbs_stb_i,
  input  logic                        wbs_we_i,
  input  logic [`PERF_ADDR_W-1:0]     wbs_adr_i,
  input  word_t                       wbs_dat_i,
  output logic                        wbs_ack_o,
  output word_t                       wbs_dat_o,
  // Wishbone master, sample stores
  output logic                        wbm_cyc_o,
  output logic                        wbm_stb_o,
  output logic                        wbm_we_o,
  output word_t                       wbm_adr_o,
  output word_t                       wbm_dat_o,
  input  logic                        wbm_ack_i,
  // From the core
  input  logic [`PERF_NUM_EVENTS-1:0] event_i,
  input  word_t                       pc_i,
  input  logic [`PERF_NUM_CNT-1:0]    inhibit_i,
  input  logic                        debug_mode_i
);

  // --------------------
  // Configuration
  // --------------------
  sel_vec_t                  sel_vec;
  cnt_vec_t                  thr_vec;
  word_t                     maddr;
  logic [`PERF_NUM_CNT-1:0]  sample_mask;
  logic                      cnt_we;
  logic [1:0]                cnt_widx;
  word_t                     cnt_wdata;
  logic                      hold_cnt;

  // --------------------
  // Counting and sampling
  // --------------------
  logic [`PERF_NUM_CNT-1:0]  hit;
  cnt_vec_t                  event_pc;
  cnt_vec_t                  cnt_vec;
  logic                      capture;
  logic [1:0]                trig_idx;
  logic                      store_req;
  logic [2:0]                store_idx;
  sample_state_e             state;
  logic                      store_done;

  perf_csr_regs i_csr_regs (
    .clk_i, .rst_ni,
    .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_adr_i, .wbs_dat_i,
    .cnt_vec_i     (cnt_vec),
    .wbs_ack_o, .wbs_dat_o,
    .sel_vec_o     (sel_vec),
    .thr_vec_o     (thr_vec),
    .maddr_o       (maddr),
    .sample_mask_o (sample_mask),
    .cnt_we_o      (cnt_we),
    .cnt_widx_o    (cnt_widx),
    .cnt_wdata_o   (cnt_wdata),
    .hold_cnt_o    (hold_cnt)
  );

  perf_event_mux i_event_mux (
    .clk_i, .rst_ni, .event_i, .pc_i,
    .sel_vec_i  (sel_vec),
    .hit_o      (hit),
    .event_pc_o (event_pc)
  );

  perf_counter_bank i_counter_bank (
    .clk_i, .rst_ni,
    .hit_i       (hit),
    .inhibit_i, .debug_mode_i,
    .hold_cnt_i  (hold_cnt),
    .cnt_we_i    (cnt_we),
    .cnt_widx_i  (cnt_widx),
    .cnt_wdata_i (cnt_wdata),
    .cnt_vec_o   (cnt_vec)
  );

  perf_sample_fsm i_sample_fsm (
    .clk_i, .rst_ni,
    .cnt_vec_i     (cnt_vec),
    .thr_vec_i     (thr_vec),
    .sample_mask_i (sample_mask),
    .store_done_i  (store_done),
    .capture_o     (capture),
    .trig_idx_o    (trig_idx),
    .store_req_o   (store_req),
    .store_idx_o   (store_idx),
    .state_o       (state)
  );

  perf_sample_store i_sample_store (
    .clk_i, .rst_ni,
    .capture_i    (capture),
    .trig_idx_i   (trig_idx),
    .cnt_vec_i    (cnt_vec),
    .event_pc_i   (event_pc),
    .maddr_i      (maddr),
    .store_req_i  (store_req),
    .store_idx_i  (store_idx),
    .state_i      (state),
    .wbm_ack_i,
    .wbm_cyc_o, .wbm_stb_o, .wbm_we_o, .wbm_adr_o, .wbm_dat_o,
    .store_done_o (store_done)
  );

endmodule

/* verification/perf_tb_vectors.svh */
// Test table of the performance-counter testbench, included in perf_tb and applied in order
`ifndef PERF_TB_VECTORS_SVH
`define PERF_TB_VECTORS_SVH

// Each entry holds name, operation, word index or strobe or store address, data, repeat, expected
task automatic load_vectors();
  // --------------------
  // Reset values
  // --------------------
  add_vector("rst_regs",   OpRead,     `PERF_REG_CNT0, 0, `PERF_REG_CFG + 1, 0);
  add_vector("rst_idle",   OpIdle,     0, 0, 20, 0);
  // --------------------
  // Register access
  // --------------------
  add_vector("sel1_wr",    OpWrite,    `PERF_REG_SEL0 + 1, 3, 1, 0);
  add_vector("sel1_rd",    OpRead,     `PERF_REG_SEL0 + 1, 0, 1, 3);
  add_vector("thr2_wr",    OpWrite,    `PERF_REG_THR0 + 2, 32'h1234_5678, 1, 0);
  add_vector("thr2_rd",    OpRead,     `PERF_REG_THR0 + 2, 0, 1, 32'h1234_5678);
  add_vector("thr2_clr",   OpWrite,    `PERF_REG_THR0 + 2, 0, 1, 0);
  add_vector("maddr_wr",   OpWrite,    `PERF_REG_MADDR, 32'h8000_0100, 1, 0);
  add_vector("maddr_rd",   OpRead,     `PERF_REG_MADDR, 0, 1, 32'h8000_0100);
  add_vector("cfg_wr",     OpWrite,    `PERF_REG_CFG, 32'hff, 1, 0);
  add_vector("cfg_rd",     OpRead,     `PERF_REG_CFG, 0, 1, 32'hf);  // Mask is 4 bits
  add_vector("unmap_wr",   OpWrite,    `PERF_REG_CFG + 2, 32'hdead, 1, 0);
  add_vector("unmap_rd",   OpRead,     `PERF_REG_CFG + 1, 0, 2, 0);
  // --------------------
  // Counting
  // --------------------
  add_vector("sel0_wr",    OpWrite,    `PERF_REG_SEL0, 3, 1, 0);  // Strobe 2
  add_vector("ev_rand",    OpEvent,    2, 32'h100, 0, 0);
  add_vector("cnt0_rand",  OpReadRand, `PERF_REG_CNT0, 0, 1, 0);
  add_vector("ev_other",   OpEvent,    5, 32'h104, 4, 0);
  add_vector("cnt0_other", OpReadRand, `PERF_REG_CNT0, 0, 1, 0);
  add_vector("inh_on",     OpCtrl,     0, 32'h01, 0, 0);
  add_vector("ev_inh",     OpEvent,    2, 32'h108, 5, 0);
  add_vector("cnt0_inh",   OpReadRand, `PERF_REG_CNT0, 0, 1, 0);
  add_vector("dbg_on",     OpCtrl,     0, 32'h10, 0, 0);
  add_vector("ev_dbg",     OpEvent,    2, 32'h10c, 5, 0);
  add_vector("cnt0_dbg",   OpReadRand, `PERF_REG_CNT0, 0, 1, 0);
  add_vector("ctl_off",    OpCtrl,     0, 0, 0, 0);
  add_vector("ev_fixed",   OpEvent,    2, 32'h110, 3, 0);
  add_vector("cnt0_fixed", OpReadRand, `PERF_REG_CNT0, 0, 1, 3);
  add_vector("sel1_ev7",   OpWrite,    `PERF_REG_SEL0 + 1, 8, 1, 0);
  add_vector("cnt1_wr",    OpWrite,    `PERF_REG_CNT0 + 1, 100, 1, 0);
  add_vector("ev_cnt1",    OpEvent,    7, 32'h200, 6, 0);
  add_vector("cnt1_sum",   OpRead,     `PERF_REG_CNT0 + 1, 0, 1, 106);
  add_vector("cnt1_top",   OpWrite,    `PERF_REG_CNT0 + 1, 32'hffff_fffe, 1, 0);
  add_vector("ev_wrap",    OpEvent,    7, 32'h204, 3, 0);
  add_vector("cnt1_wrap",  OpRead,     `PERF_REG_CNT0 + 1, 0, 1, 1);
  // --------------------
  // Sampling
  // --------------------
  add_vector("cnt0_clr",   OpWrite,    `PERF_REG_CNT0, 0, 1, 0);
  add_vector("sel2_ev0",   OpWrite,    `PERF_REG_SEL0 + 2, 1, 1, 0);
  add_vector("base_wr",    OpWrite,    `PERF_REG_MADDR, 32'h1000, 1, 0);
  add_vector("mask_02",    OpWrite,    `PERF_REG_CFG, 32'h5, 1, 0);
  add_vector("thr2_set",   OpWrite,    `PERF_REG_THR0 + 2, 5, 1, 0);
  add_vector("ev_cross1",  OpEvent,    0, 32'h400, 5, 0);
  add_vector("st1_pc",     OpPop,      32'h1000, 0, 0, 32'h400);
  add_vector("st1_cnt0",   OpPop,      32'h1004, 0, 0, 0);
  add_vector("st1_cnt2",   OpPop,      32'h1008, 0, 0, 5);
  add_vector("st1_idle",   OpIdle,     0, 0, 10, 0);
  add_vector("mask_012",   OpWrite,    `PERF_REG_CFG, 32'h7, 1, 0);
  add_vector("ev_below",   OpEvent,    0, 32'h500, 4, 0);
  add_vector("below_idle", OpIdle,     0, 0, 10, 0);  // Offset keeps it quiet
  add_vector("ev_cross2",  OpEvent,    0, 32'h504, 1, 0);
  add_vector("st2_pc",     OpPop,      32'h100c, 0, 0, 32'h504);
  add_vector("st2_cnt0",   OpPop,      32'h1010, 0, 0, 0);
  add_vector("st2_cnt1",   OpPop,      32'h1014, 0, 0, 1);
  add_vector("st2_cnt2",   OpPop,      32'h1018, 0, 0, 10);
  add_vector("st2_idle",   OpIdle,     0, 0, 10, 0);
  add_vector("cnt2_rd",    OpRead,     `PERF_REG_CNT0 + 2, 0, 1, 10);
endtask

`endif

/* verification/perf_tb.sv */
// Testbench of perf_top with clock, reset, Wishbone memory model and the table-driven test loop
`timescale 1ns/1ps
`include "perf_defines.svh"

module perf_tb import perf_pkg::*; ();

  localparam int WaitLimit = 200;  // Cycles per wait before giving up
  localparam int MaxVec    = 128;
  localparam int OpWrite    = 0;
  localparam int OpRead     = 1;
  localparam int OpReadRand = 2;   // Expected value plus all random pulses so far
  localparam int OpEvent    = 3;   // Repeat 0 means a random pulse count
  localparam int OpCtrl     = 4;   // Data bits 3..0 inhibit, bit 4 debug mode
  localparam int OpPop      = 5;
  localparam int OpIdle     = 6;

  logic clk_i;
  logic rst_ni;
  logic wbs_cyc_i, wbs_stb_i, wbs_we_i;
  logic [`PERF_ADDR_W-1:0] wbs_adr_i;
  word_t wbs_dat_i, wbs_dat_o;
  logic wbs_ack_o;
  logic wbm_cyc_o, wbm_stb_o, wbm_we_o, wbm_ack_i;
  word_t wbm_adr_o, wbm_dat_o;
  logic [`PERF_NUM_EVENTS-1:0] event_i;
  word_t pc_i;
  logic [`PERF_NUM_CNT-1:0] inhibit_i;
  logic debug_mode_i;

  string vec_name[MaxVec];
  int    vec_op[MaxVec];
  int    vec_rep[MaxVec];
  word_t vec_addr[MaxVec], vec_data[MaxVec], vec_exp[MaxVec];
  int    num_vec = 0;
  int    errors = 0;
  int    tests = 0;
  bit    abort = 1'b0;
  word_t ev_rng = 38;
  word_t mem_rng = 38;
  word_t rand_sum = 0;
  int    ack_wait = 0;
  word_t st_adr[$];
  word_t st_dat[$];

  perf_top uut (
    .clk_i, .rst_ni,
    .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_adr_i, .wbs_dat_i, .wbs_ack_o, .wbs_dat_o,
    .wbm_cyc_o, .wbm_stb_o, .wbm_we_o, .wbm_adr_o, .wbm_dat_o, .wbm_ack_i,
    .event_i, .pc_i, .inhibit_i, .debug_mode_i
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic add_vector(input string name, input int op, input word_t addr,
                            input word_t data, input int rep, input word_t exp);
    vec_name[num_vec] = name;
    vec_op[num_vec]   = op;
    vec_addr[num_vec] = addr;
    vec_data[num_vec] = data;
    vec_rep[num_vec]  = rep;
    vec_exp[num_vec]  = exp;
    num_vec++;
  endtask

  `include "perf_tb_vectors.svh"

  // --------------------
  // Checks
  // --------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input sample_state_e exp,
                             input sample_state_e act);
    if (exp !== act) begin
      $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("%s: timed out after %0d cycles waiting for %s", name, WaitLimit, what);
    errors++;
    abort = 1'b1;
  endtask

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic access_reg(input string name, input bit we, input word_t idx,
                            input word_t wdata, output word_t rdata);
    int t;
    @(posedge clk_i);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_adr_i <= `PERF_ADDR_W'(idx << 2);
    wbs_dat_i <= wdata;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!wbs_ack_o && t < WaitLimit);
    rdata = wbs_dat_o;  // Valid with the ack
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    if (!wbs_ack_o) report_timeout(name, "the slave ack");
  endtask

  task automatic pulse_event(input int code, input word_t pc, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      event_i <= `PERF_NUM_EVENTS'(1) << code;
      pc_i    <= pc;
      @(posedge clk_i);
      event_i <= '0;
    end
  endtask

  task automatic pop_store(input string name, input word_t exp_adr, input word_t exp_dat);
    int t;
    t = 0;
    while (st_adr.size() == 0 && t < WaitLimit) begin
      @(posedge clk_i);
      t++;
    end
    if (st_adr.size() == 0) begin
      report_timeout(name, "a master write");
    end else begin
      check_word({name, "_adr"}, exp_adr, st_adr.pop_front());
      check_word(name, exp_dat, st_dat.pop_front());
    end
  endtask

  task automatic watch_idle(input string name, input int n);
    int t;
    logic cyc_seen;
    t = 0;
    cyc_seen = 1'b0;
    while (uut.state != SMP_IDLE && t < WaitLimit) begin
      @(posedge clk_i);
      t++;
    end
    if (uut.state != SMP_IDLE) begin
      report_timeout(name, "the sampler to go idle");
    end else begin
      repeat (n) begin
        @(posedge clk_i);
        if (wbm_cyc_o) cyc_seen = 1'b1;
      end
      check_state(name, SMP_IDLE, uut.state);
      check_word({name, "_cyc"}, '0, word_t'(cyc_seen));
      check_word({name, "_writes"}, '0, word_t'(st_adr.size()));  // No stray stores
    end
  endtask

  task automatic run_vector(input int v);
    word_t rd;
    int    n;
    case (vec_op[v])
      OpWrite: access_reg(vec_name[v], 1'b1, vec_addr[v], vec_data[v], rd);
      OpRead: begin
        for (int i = 0; i < vec_rep[v] && !abort; i++) begin
          access_reg(vec_name[v], 1'b0, vec_addr[v] + i, '0, rd);
          check_word(vec_name[v], vec_exp[v], rd);
        end
      end
      OpReadRand: begin
        access_reg(vec_name[v], 1'b0, vec_addr[v], '0, rd);
        check_word(vec_name[v], vec_exp[v] + rand_sum, rd);
      end
      OpEvent: begin
        n = vec_rep[v];
        if (n == 0) begin
          ev_rng   = xorshift32(ev_rng);
          n        = 1 + int'(ev_rng % 16);
          rand_sum = rand_sum + word_t'(n);
        end
        pulse_event(int'(vec_addr[v]), vec_data[v], n);
      end
      OpCtrl: begin
        @(posedge clk_i);
        inhibit_i    <= vec_data[v][`PERF_NUM_CNT-1:0];
        debug_mode_i <= vec_data[v][4];
      end
      OpPop:   pop_store(vec_name[v], vec_addr[v], vec_exp[v]);
      default: watch_idle(vec_name[v], vec_rep[v]);
    endcase
  endtask

  // Memory model that acks each master write after 0 to 3 wait cycles
  always @(posedge clk_i) begin
    if (wbm_ack_i) begin
      wbm_ack_i <= 1'b0;
    end else if (wbm_cyc_o && wbm_stb_o && wbm_we_o) begin
      if (ack_wait == 0) begin
        st_adr.push_back(wbm_adr_o);
        st_dat.push_back(wbm_dat_o);
        wbm_ack_i <= 1'b1;
        mem_rng = xorshift32(mem_rng);
        ack_wait <= int'(mem_rng % 4);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  // --------------------
  // Test loop
  // --------------------
  initial begin
    int errs_before;
    rst_ni <= 1'b0;
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i <= 1'b0;
    wbs_adr_i <= '0;
    wbs_dat_i <= '0;
    wbm_ack_i <= 1'b0;
    event_i <= '0;
    pc_i <= '0;
    inhibit_i <= '0;
    debug_mode_i <= 1'b0;
    load_vectors();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int v = 0; v < num_vec && !abort; v++) begin
      errs_before = errors;
      run_vector(v);
      tests++;
      $display("%-12s %s", vec_name[v], (errors == errs_before) ? "ok" : "FAILED");
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
+incdir+verification
logic/perf_pkg.sv
logic/perf_event_mux.sv
logic/perf_counter_bank.sv
logic/perf_csr_regs.sv
logic/perf_sample_fsm.sv
logic/perf_sample_store.sv
logic/perf_top.sv
verification/perf_tb.sv

/* Bender.yml */
package:
  name: perf_counters

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/perf_pkg.sv
      - logic/perf_event_mux.sv
      - logic/perf_counter_bank.sv
      - logic/perf_csr_regs.sv
      - logic/perf_sample_fsm.sv
      - logic/perf_sample_store.sv
      - logic/perf_top.sv
  - target: test
    include_dirs:
      - logic
      - verification
    files:
      - verification/perf_tb.sv
